//--- hdl/tex_consts.svh
`ifndef TEX_CONSTS_SVH
`define TEX_CONSTS_SVH

// stage configuration.
`define TEX_NUM_STAGES      4
`define TEX_STAGE_BITS      2

// datapath widths.
`define TEX_ADDR_BITS       32
`define TEX_COORD_BITS      16
`define TEX_LOD_BITS        4
`define TEX_LOD_MAX         7
`define TEX_FORMAT_BITS     2
`define TEX_WRAP_BITS       2

// dcr bus.
`define TEX_DCR_ADDR_BITS   8
`define TEX_DCR_DATA_BITS   32

// dcr register map.
`define TEX_DCR_STAGE       8'h00
`define TEX_DCR_ADDR        8'h01
`define TEX_DCR_FORMAT      8'h02
`define TEX_DCR_WRAP        8'h03  // V in the upper half.
`define TEX_DCR_LOGDIM      8'h04  // V in the upper half.
`define TEX_DCR_MIPOFF_BASE 8'h05

`define TEX_DCR_HI_LSB      16

`endif

//--- hdl/tex_pkg.sv
`include "tex_consts.svh"

package tex_pkg;

    typedef enum logic [`TEX_WRAP_BITS-1:0] {
        TEX_WRAP_CLAMP  = 2'd0,
        TEX_WRAP_REPEAT = 2'd1,
        TEX_WRAP_MIRROR = 2'd2
    } tex_wrap_e;

    typedef enum logic [`TEX_FORMAT_BITS-1:0] {
        TEX_FMT_R8     = 2'd0,  // 1 byte.
        TEX_FMT_RGB565 = 2'd1,  // 2 bytes.
        TEX_FMT_RGBA8  = 2'd2   // 4 bytes.
    } tex_format_e;

    typedef struct packed {
        logic                          valid;
        logic [`TEX_DCR_ADDR_BITS-1:0] addr;
        logic [`TEX_DCR_DATA_BITS-1:0] data;
    } tex_dcr_wr_t;

    typedef struct packed {
        logic [`TEX_ADDR_BITS-1:0]                  baseaddr;
        tex_format_e                                format;
        tex_wrap_e                                  wrap_u;
        tex_wrap_e                                  wrap_v;
        logic [`TEX_LOD_BITS-1:0]                   logdim_u;
        logic [`TEX_LOD_BITS-1:0]                   logdim_v;
        logic [`TEX_LOD_MAX:0][`TEX_ADDR_BITS-1:0]  mipoff;
    } tex_dcrs_t;

    typedef struct packed {
        logic [`TEX_STAGE_BITS-1:0]        stage;
        logic [`TEX_LOD_BITS-1:0]          lod;
        logic signed [`TEX_COORD_BITS-1:0] u;
        logic signed [`TEX_COORD_BITS-1:0] v;
    } tex_req_t;

    typedef struct packed {
        logic [`TEX_ADDR_BITS-1:0] addr;
    } tex_rsp_t;

    // log2 of the texel size in bytes.
    function automatic logic [1:0] tex_texel_shift(tex_format_e fmt);
        case (fmt)
            TEX_FMT_RGB565: return 2'd1;
            TEX_FMT_RGBA8:  return 2'd2;
            default:        return 2'd0;
        endcase
    endfunction

endpackage

//--- hdl/tex_dcr.sv
`timescale 1ns/100ps

`include "tex_consts.svh"

module tex_dcr (
    input  logic                       clk,
    input  tex_pkg::tex_dcr_wr_t       dcr_wr,
    input  logic [`TEX_STAGE_BITS-1:0] stage,
    output tex_pkg::tex_dcrs_t         dcrs
);

    logic [`TEX_STAGE_BITS-1:0] cur_stage;
    tex_pkg::tex_dcrs_t         regs [`TEX_NUM_STAGES];

    always_ff @(posedge clk) begin
        if (dcr_wr.valid) begin
            case (dcr_wr.addr)
                `TEX_DCR_STAGE: begin
                    cur_stage <= dcr_wr.data[`TEX_STAGE_BITS-1:0];
                end
                `TEX_DCR_ADDR: begin
                    regs[cur_stage].baseaddr <= dcr_wr.data[`TEX_ADDR_BITS-1:0];
                end
                `TEX_DCR_FORMAT: begin
                    regs[cur_stage].format <=
                        tex_pkg::tex_format_e'(dcr_wr.data[`TEX_FORMAT_BITS-1:0]);
                end
                `TEX_DCR_WRAP: begin
                    regs[cur_stage].wrap_u <=
                        tex_pkg::tex_wrap_e'(dcr_wr.data[0 +: `TEX_WRAP_BITS]);
                    regs[cur_stage].wrap_v <=
                        tex_pkg::tex_wrap_e'(dcr_wr.data[`TEX_DCR_HI_LSB +: `TEX_WRAP_BITS]);
                end
                `TEX_DCR_LOGDIM: begin
                    regs[cur_stage].logdim_u <= dcr_wr.data[0 +: `TEX_LOD_BITS];
                    regs[cur_stage].logdim_v <= dcr_wr.data[`TEX_DCR_HI_LSB +: `TEX_LOD_BITS];
                end
                default: begin
                    // mip offsets occupy a contiguous range.
                    for (int j = 0; j <= `TEX_LOD_MAX; j++) begin
                        if (dcr_wr.addr == `TEX_DCR_ADDR_BITS'(`TEX_DCR_MIPOFF_BASE + j)) begin
                            regs[cur_stage].mipoff[j] <= dcr_wr.data[`TEX_ADDR_BITS-1:0];
                        end
                    end
                end
            endcase
        end
    end

    assign dcrs = regs[stage];  // combinational read.

endmodule

//--- hdl/tex_wrap.sv
`timescale 1ns/100ps

`include "tex_consts.svh"

module tex_wrap (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  logic signed [`TEX_COORD_BITS-1:0] coord,
    input  tex_pkg::tex_wrap_e                mode,
    input  logic [`TEX_LOD_BITS-1:0]          logdim,
    output logic [`TEX_COORD_BITS-1:0]        wrapped,
    output logic                              done
);

    logic [`TEX_COORD_BITS-1:0] dim_mask;
    logic [`TEX_COORD_BITS-1:0] wrap_c;

    assign dim_mask = (`TEX_COORD_BITS'(1) << logdim) - `TEX_COORD_BITS'(1);

    always_comb begin
        case (mode)
            tex_pkg::TEX_WRAP_CLAMP: begin
                if (coord[`TEX_COORD_BITS-1])
                    wrap_c = '0;                       // below zero.
                else if ((coord & ~dim_mask) != '0)
                    wrap_c = dim_mask;                 // past dim-1.
                else
                    wrap_c = coord;
            end
            tex_pkg::TEX_WRAP_MIRROR: begin
                if (coord[logdim])
                    wrap_c = ~coord & dim_mask;        // odd period runs backwards.
                else
                    wrap_c = coord & dim_mask;
            end
            default: wrap_c = coord & dim_mask;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wrapped <= wrap_c;
        end
    end

endmodule

//--- hdl/tex_addr_gen.sv
`timescale 1ns/100ps

`include "tex_consts.svh"

module tex_addr_gen (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [`TEX_COORD_BITS-1:0]  u,
    input  logic [`TEX_COORD_BITS-1:0]  v,
    input  logic [`TEX_LOD_BITS-1:0]    logdim_u,
    input  tex_pkg::tex_dcrs_t          cfg,
    input  logic [`TEX_LOD_BITS-1:0]    lod,
    output tex_pkg::tex_rsp_t           rsp,
    output logic                        valid
);

    logic [`TEX_ADDR_BITS-1:0] index;
    logic [`TEX_ADDR_BITS-1:0] byte_off;
    logic [`TEX_ADDR_BITS-1:0] level_base;
    logic [`TEX_ADDR_BITS-1:0] addr_c;

    // row-major texel index at this mip level.
    assign index = (`TEX_ADDR_BITS'(v) << logdim_u) + `TEX_ADDR_BITS'(u);

    assign byte_off = index << tex_pkg::tex_texel_shift(cfg.format);

    // lod is bounded to TEX_LOD_MAX by the controller.
    assign level_base = cfg.baseaddr + cfg.mipoff[lod];

    assign addr_c = level_base + byte_off;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rsp.addr <= addr_c;
        end
    end

endmodule

//--- hdl/tex_unit.sv
`timescale 1ns/100ps

`include "tex_consts.svh"

module tex_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  tex_pkg::tex_dcr_wr_t dcr_wr,
    input  logic                 req_valid,
    input  tex_pkg::tex_req_t    req,
    output logic                 req_ack,
    output tex_pkg::tex_rsp_t    rsp
);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_ACK, ST_RELEASE} state_e;

    state_e                            state;
    logic                              start;
    tex_pkg::tex_dcrs_t                dcrs;
    tex_pkg::tex_dcrs_t                cfg_q;
    logic signed [`TEX_COORD_BITS-1:0] u_q;
    logic signed [`TEX_COORD_BITS-1:0] v_q;
    logic [`TEX_LOD_BITS-1:0]          lod_c;
    logic [`TEX_LOD_BITS-1:0]          lod_q;
    logic [`TEX_LOD_BITS-1:0]          logdim_u_q;
    logic [`TEX_LOD_BITS-1:0]          logdim_v_q;
    logic [`TEX_COORD_BITS-1:0]        u_wrapped;
    logic [`TEX_COORD_BITS-1:0]        v_wrapped;
    logic                              u_done;
    logic                              v_done;
    logic                              addr_valid;

    assign lod_c = (req.lod > `TEX_LOD_MAX) ? `TEX_LOD_BITS'(`TEX_LOD_MAX) : req.lod;

    // four-phase port controller.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            start   <= 1'b0;
            req_ack <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                ST_IDLE: if (req_valid) begin
                    start <= 1'b1;
                    state <= ST_BUSY;
                end
                ST_BUSY: if (addr_valid) begin
                    req_ack <= 1'b1;
                    state   <= ST_ACK;
                end
                ST_ACK: if (!req_valid) begin
                    req_ack <= 1'b0;
                    state   <= ST_RELEASE;
                end
                default: state <= ST_IDLE;  // one idle cycle after release.
            endcase
        end
    end

    // request and config snapshot. mip-reduced dims floor at zero.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            cfg_q      <= dcrs;
            u_q        <= req.u;
            v_q        <= req.v;
            lod_q      <= lod_c;
            logdim_u_q <= (dcrs.logdim_u > lod_c) ? dcrs.logdim_u - lod_c : '0;
            logdim_v_q <= (dcrs.logdim_v > lod_c) ? dcrs.logdim_v - lod_c : '0;
        end
    end

    tex_dcr u_dcr (
        .clk    (clk),
        .dcr_wr (dcr_wr),
        .stage  (req.stage),
        .dcrs   (dcrs)
    );

    tex_wrap u_wrap (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .coord   (u_q),
        .mode    (cfg_q.wrap_u),
        .logdim  (logdim_u_q),
        .wrapped (u_wrapped),
        .done    (u_done)
    );

    tex_wrap v_wrap (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .coord   (v_q),
        .mode    (cfg_q.wrap_v),
        .logdim  (logdim_v_q),
        .wrapped (v_wrapped),
        .done    (v_done)
    );

    tex_addr_gen u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (u_done & v_done),
        .u        (u_wrapped),
        .v        (v_wrapped),
        .logdim_u (logdim_u_q),
        .cfg      (cfg_q),
        .lod      (lod_q),
        .rsp      (rsp),
        .valid    (addr_valid)
    );

endmodule

//--- verif/tex_clkgen.sv
`timescale 1ns/100ps

module tex_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/tex_unit_tb.sv
`timescale 1ns/100ps

`include "tex_consts.svh"

module tex_unit_tb;

    logic                 clk;
    logic                 rst_n;
    tex_pkg::tex_dcr_wr_t dcr_wr;
    logic                 req_valid;
    tex_pkg::tex_req_t    req;
    logic                 req_ack;
    tex_pkg::tex_rsp_t    rsp;
    tex_pkg::tex_dcrs_t   mirror [`TEX_NUM_STAGES];  // expected stage config.
    logic [15:0]          lfsr = 16'd51508;
    int                   errors = 0;
    int                   checks = 0;
    bit                   aborted = 1'b0;

    tex_clkgen clkgen (.clk(clk), .rst_n(rst_n));

    tex_unit uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .dcr_wr    (dcr_wr),
        .req_valid (req_valid),
        .req       (req),
        .req_ack   (req_ack),
        .rsp       (rsp)
    );

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};  // taps 16,14,13,11.
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, want);
        end
    endtask

    function automatic int wrap_coord(int c, tex_pkg::tex_wrap_e mode, int ld);
        int dim;
        int m;
        int period;
        dim = 1 << ld;
        m = c % dim;
        if (m < 0) m += dim;
        period = (c - m) / dim;
        case (mode)
            tex_pkg::TEX_WRAP_CLAMP:  return (c < 0) ? 0 : ((c > dim - 1) ? dim - 1 : c);
            tex_pkg::TEX_WRAP_MIRROR: return period[0] ? dim - 1 - m : m;  // odd periods reversed.
            default:                  return m;
        endcase
    endfunction

    function automatic logic [31:0] expected_addr(tex_pkg::tex_req_t r);
        tex_pkg::tex_dcrs_t c;
        int lod;
        int lu;
        int lv;
        int size;
        c = mirror[r.stage];
        lod = (r.lod > `TEX_LOD_MAX) ? `TEX_LOD_MAX : r.lod;
        lu = (c.logdim_u > lod) ? c.logdim_u - lod : 0;
        lv = (c.logdim_v > lod) ? c.logdim_v - lod : 0;
        size = (c.format == tex_pkg::TEX_FMT_R8) ? 1 :
               (c.format == tex_pkg::TEX_FMT_RGB565) ? 2 : 4;
        return c.baseaddr + c.mipoff[lod] + size * (wrap_coord(r.v, c.wrap_v, lv) * (1 << lu)
               + wrap_coord(r.u, c.wrap_u, lu));
    endfunction

    function automatic tex_pkg::tex_req_t make_req(int stage, int lod, int u, int v);
        tex_pkg::tex_req_t r;
        r.stage = `TEX_STAGE_BITS'(stage);
        r.lod   = `TEX_LOD_BITS'(lod);
        r.u     = `TEX_COORD_BITS'(u);
        r.v     = `TEX_COORD_BITS'(v);
        return r;
    endfunction

    task automatic dcr_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        dcr_wr <= {1'b1, addr, data};
        @(posedge clk);
        dcr_wr <= '0;
    endtask

    task automatic program_stage(input int s, input logic [31:0] base,
                                 input tex_pkg::tex_format_e fmt, input tex_pkg::tex_wrap_e wu,
                                 input tex_pkg::tex_wrap_e wv, input logic [3:0] lu,
                                 input logic [3:0] lv);
        dcr_write(`TEX_DCR_STAGE, s);
        dcr_write(`TEX_DCR_ADDR, base);
        dcr_write(`TEX_DCR_FORMAT, {30'd0, fmt});
        dcr_write(`TEX_DCR_WRAP, {14'd0, wv, 14'd0, wu});
        dcr_write(`TEX_DCR_LOGDIM, {12'd0, lv, 12'd0, lu});
        for (int j = 0; j <= `TEX_LOD_MAX; j++) begin
            mirror[s].mipoff[j] = j * 32'h0010_0000 + s * 32'h100;
            dcr_write(`TEX_DCR_MIPOFF_BASE + j, mirror[s].mipoff[j]);
        end
        mirror[s].baseaddr = base;
        mirror[s].format   = fmt;
        mirror[s].wrap_u   = wu;
        mirror[s].wrap_v   = wv;
        mirror[s].logdim_u = lu;
        mirror[s].logdim_v = lv;
    endtask

    task automatic wait_ack(input logic level, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < 20 && !ok; i++) begin
            @(negedge clk);
            ok = (req_ack === level);
        end
    endtask

    task automatic sample(input tex_pkg::tex_req_t r, input int hold,
                          output tex_pkg::tex_rsp_t got);
        bit ok;
        got = '0;
        if (!aborted) begin
            @(posedge clk);
            req       <= r;
            req_valid <= 1'b1;
            wait_ack(1'b1, ok);
            got = rsp;
            for (int i = 0; i < hold && ok; i++) begin
                @(negedge clk);
                check("req_ack", req_ack, 32'd1);  // held while req_valid stays high.
                check("rsp.addr", rsp.addr, got.addr);
            end
            @(posedge clk);
            req_valid <= 1'b0;
            if (ok) wait_ack(1'b0, ok);
            if (!ok) begin
                $display("timeout: req_ack did not follow req_valid within 20 cycles");
                errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic sample_and_compare(input tex_pkg::tex_req_t r, input int hold);
        logic [31:0]       want;
        tex_pkg::tex_rsp_t got;
        want = expected_addr(r);
        sample(r, hold, got);
        if (!aborted) check("rsp.addr", got.addr, want);
    endtask

    task automatic test_basic();
        tex_pkg::tex_rsp_t got;
        program_stage(0, 32'h1000_0000, tex_pkg::TEX_FMT_RGBA8, tex_pkg::TEX_WRAP_REPEAT,
                      tex_pkg::TEX_WRAP_REPEAT, 4'd4, 4'd3);
        sample(make_req(0, 0, 5, 6), 0, got);
        check("rsp.addr", got.addr, 32'h1000_0000 + (6 * 16 + 5) * 4);
        sample_and_compare(make_req(0, 0, 15, 7), 0);
    endtask

    task automatic test_wrap_modes();
        int cu [5];
        int cv [5];
        cu = '{-3, 20, 7, -9, 8};
        cv = '{-3, 9, 15, 17, -8};
        for (int m = 0; m < 3; m++) begin
            program_stage(1, 32'h2000_0000, tex_pkg::TEX_FMT_RGB565, tex_pkg::tex_wrap_e'(m),
                          tex_pkg::tex_wrap_e'((m + 1) % 3), 4'd3, 4'd3);
            for (int i = 0; i < 5; i++) sample_and_compare(make_req(1, 0, cu[i], cv[i]), 0);
        end
    endtask

    task automatic test_mips();
        program_stage(2, 32'h3000_0000, tex_pkg::TEX_FMT_R8, tex_pkg::TEX_WRAP_REPEAT,
                      tex_pkg::TEX_WRAP_MIRROR, 4'd5, 4'd4);
        for (int lod = 0; lod < 10; lod++) sample_and_compare(make_req(2, lod, 37, -5), 0);
    endtask

    task automatic test_formats();
        for (int s = 0; s < 3; s++) begin
            program_stage(s, 32'h100 + s * 32'h4000, tex_pkg::tex_format_e'(s),
                          tex_pkg::TEX_WRAP_REPEAT, tex_pkg::TEX_WRAP_CLAMP, 4'd4, 4'd4);
        end
        program_stage(3, 32'hC000, tex_pkg::TEX_FMT_RGBA8, tex_pkg::TEX_WRAP_MIRROR,
                      tex_pkg::TEX_WRAP_REPEAT, 4'd2, 4'd6);
        for (int s = 0; s < 4; s++) sample_and_compare(make_req(s, 1, 3, 2), 0);
    endtask

    task automatic test_handshake();
        fork
            sample_and_compare(make_req(3, 0, 9, 5), 5);
            begin
                repeat (1) @(posedge clk);
                dcr_write(`TEX_DCR_ADDR, 32'h0BAD_0000);  // lands after capture.
            end
        join
        mirror[3].baseaddr = 32'h0BAD_0000;
        sample_and_compare(make_req(3, 0, 9, 5), 2);
    endtask

    task automatic test_random();
        for (int s = 0; s < `TEX_NUM_STAGES; s++) begin
            program_stage(s, rand_bits(32), tex_pkg::tex_format_e'(rand_bits(4) % 3),
                          tex_pkg::tex_wrap_e'(rand_bits(4) % 3),
                          tex_pkg::tex_wrap_e'(rand_bits(4) % 3), rand_bits(3), rand_bits(3));
        end
        for (int i = 0; i < 50; i++) begin
            sample_and_compare(make_req(rand_bits(2), rand_bits(4), rand_bits(16),
                                        rand_bits(16)), 0);
        end
    endtask

    initial begin
        bit up;
        dcr_wr    = '0;
        req_valid = 1'b0;
        req       = '0;
        up        = 1'b0;
        for (int i = 0; i < 30 && !up; i++) begin
            @(negedge clk);
            up = rst_n;
        end
        if (!up) begin
            $display("reset was never released");
            errors++;
            aborted = 1'b1;
        end
        test_basic();
        test_wrap_modes();
        test_mips();
        test_formats();
        test_handshake();
        test_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/tex_pkg.sv
hdl/tex_dcr.sv
hdl/tex_wrap.sv
hdl/tex_addr_gen.sv
hdl/tex_unit.sv
verif/tex_clkgen.sv
verif/tex_unit_tb.sv

//--- Bender.yml
package:
  name: tex_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tex_pkg.sv
      - hdl/tex_dcr.sv
      - hdl/tex_wrap.sv
      - hdl/tex_addr_gen.sv
      - hdl/tex_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tex_clkgen.sv
      - verif/tex_unit_tb.sv
